//--- common/fb_pkg.sv
`default_nettype none

package fb_pkg;

    ////////////////////
    // data types
    ////////////////////

    // colour index, also the width of one output channel
    typedef logic [3:0] pixel_t;

    // linear pixel address, covers 640 x 480
    typedef logic [18:0] fb_addr_t;

    // scan position
    typedef logic [8:0] row_t;
    typedef logic [9:0] col_t;

    ////////////////////
    // default frame geometry
    ////////////////////

    localparam int H_PIXELS = 640;
    localparam int V_PIXELS = 480;

    // last row of the red band
    localparam int RED_ROWS = 120;

endpackage

`default_nettype wire

//--- common/fb_bank_if.sv
`timescale 1ns/10ps
`default_nettype none

// one port of a bank memory
interface fb_bank_if;

    fb_pkg::fb_addr_t addr;
    fb_pkg::pixel_t   wdata;
    fb_pkg::pixel_t   rdata;
    logic             en;
    logic             we;

    // controller side steers address and data in
    modport ctrl (
        output addr,
        output wdata,
        output en,
        output we,
        input  rdata
    );

    // memory side returns registered read data
    modport mem (
        input  addr,
        input  wdata,
        input  en,
        input  we,
        output rdata
    );

endinterface

`default_nettype wire

//--- frame_buffer/fb_bank.sv
`timescale 1ns/10ps
`default_nettype none

module fb_bank (
    input wire     clk,
    fb_bank_if.mem bank
);

    // full address range of fb_addr_t
    localparam int DEPTH = 2 ** $bits(fb_pkg::fb_addr_t);

    fb_pkg::pixel_t ram [DEPTH];

    ////////////////////
    // single port access
    ////////////////////

    // write when we is set, otherwise read
    // rdata keeps the last word read
    always_ff @(posedge clk) begin
        if (bank.en) begin
            if (bank.we) begin
                ram[bank.addr] <= bank.wdata;
            end else begin
                bank.rdata <= ram[bank.addr];
            end
        end
    end

    ////////////////////
    // checks
    ////////////////////

    // controller must never ask for a write on an idle port
    a_we_needs_en : assert property (
        @(posedge clk) bank.we |-> bank.en
    ) else $error("fb_bank: we high while en low");

endmodule

`default_nettype wire

//--- frame_buffer/fb_controller.sv
`timescale 1ns/10ps
`default_nettype none

module fb_controller #(
    parameter int H_PIXELS = fb_pkg::H_PIXELS,
    parameter int V_PIXELS = fb_pkg::V_PIXELS,
    parameter int RED_ROWS = fb_pkg::RED_ROWS
) (
    input wire                     clk,
    input wire                     rst,
    input wire                     frame_start,
    input wire                     read_swap,
    input wire fb_pkg::fb_addr_t   w_addr,
    input wire                     en_w,
    input wire fb_pkg::pixel_t     color_in,
    input wire fb_pkg::row_t       row,
    input wire fb_pkg::col_t       col,
    input wire                     en_r,
    fb_bank_if.ctrl                bank_a,
    fb_bank_if.ctrl                bank_b,
    output fb_pkg::pixel_t         red_out,
    output fb_pkg::pixel_t         green_out,
    output fb_pkg::pixel_t         blue_out
);

    localparam fb_pkg::fb_addr_t FRAME_WORDS = fb_pkg::fb_addr_t'(H_PIXELS * V_PIXELS);

    // read x means x is displayed and write y means y is being drawn
    typedef enum logic [1:0] {
        read_a  = 2'b00,
        write_b = 2'b01,
        read_b  = 2'b10,
        write_a = 2'b11
    } state_t;

    state_t state;
    state_t state_next;

    logic             disp_b;
    logic             writing;
    fb_pkg::fb_addr_t r_addr;
    fb_pkg::fb_addr_t clear_addr;

    // registered alongside the bank read
    logic             rd_valid;
    logic             sel_b_q;
    logic             band_red_q;
    fb_pkg::pixel_t   color;
    fb_pkg::pixel_t   pixel;

    ////////////////////
    // bank role fsm
    ////////////////////

    always_comb begin
        state_next = state;
        case (state)
            read_a:  if (frame_start) state_next = write_b;
            write_b: if (read_swap) state_next = read_b;
            read_b:  if (frame_start) state_next = write_a;
            write_a: if (read_swap) state_next = read_a;
            default: state_next = read_a;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= read_a;
        end else begin
            state <= state_next;
        end
    end

    assign disp_b  = (state == read_b) || (state == write_a);
    assign writing = (state == write_a) || (state == write_b);

    ////////////////////
    // clear sweep
    ////////////////////

    // back bank is wiped one word per cycle while nobody draws
    always_ff @(posedge clk) begin
        if (rst) begin
            clear_addr <= '0;
        end else if (!writing) begin
            if (clear_addr == FRAME_WORDS - 1'b1) begin
                clear_addr <= '0;
            end else begin
                clear_addr <= clear_addr + 1'b1;
            end
        end
    end

    ////////////////////
    // address and data steering
    ////////////////////

    assign r_addr = fb_pkg::fb_addr_t'(row) * fb_pkg::fb_addr_t'(H_PIXELS)
                  + fb_pkg::fb_addr_t'(col);

    always_comb begin
        // displayed bank only reads
        if (disp_b) begin
            bank_b.addr  = r_addr;
            bank_b.wdata = '0;
            bank_b.en    = en_r && !rst;
            bank_b.we    = 1'b0;
        end else begin
            bank_a.addr  = r_addr;
            bank_a.wdata = '0;
            bank_a.en    = en_r && !rst;
            bank_a.we    = 1'b0;
        end

        // back bank takes the writer or the clear sweep
        if (disp_b) begin
            bank_a.addr  = writing ? w_addr : clear_addr;
            bank_a.wdata = writing ? color_in : '0;
            bank_a.en    = !rst && (writing ? en_w : 1'b1);
            bank_a.we    = !rst && (writing ? en_w : 1'b1);
        end else begin
            bank_b.addr  = writing ? w_addr : clear_addr;
            bank_b.wdata = writing ? color_in : '0;
            bank_b.en    = !rst && (writing ? en_w : 1'b1);
            bank_b.we    = !rst && (writing ? en_w : 1'b1);
        end
    end

    ////////////////////
    // output select and banding
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid   <= 1'b0;
            sel_b_q    <= 1'b0;
            band_red_q <= 1'b0;
        end else begin
            rd_valid   <= en_r;
            sel_b_q    <= disp_b;
            band_red_q <= (row <= fb_pkg::row_t'(RED_ROWS));
        end
    end

    assign color = sel_b_q ? bank_b.rdata : bank_a.rdata;

    // blank between reads
    assign pixel = rd_valid ? color : '0;

    assign red_out   = band_red_q ? pixel : '0;
    assign green_out = band_red_q ? '0 : pixel;
    assign blue_out  = '0;

    ////////////////////
    // checks
    ////////////////////

    a_disp_no_write : assert property (
        @(posedge clk) disable iff (rst)
        disp_b ? !bank_b.we : !bank_a.we
    ) else $error("fb_controller: write into displayed bank");

    a_clear_range : assert property (
        @(posedge clk) disable iff (rst)
        clear_addr < FRAME_WORDS
    ) else $error("fb_controller: clear address past frame end");

endmodule

`default_nettype wire

//--- logic/swap_sync.sv
`timescale 1ns/10ps
`default_nettype none

module swap_sync (
    input wire    clk,
    input wire    rst,
    input wire    vggo,
    input wire    halt,
    input wire    lrq_empty,
    input wire    line_done,
    output logic  frame_start,
    output logic  read_swap
);

    typedef enum logic [1:0] {
        idle        = 2'b00,
        halted      = 2'b01,
        queue_empty = 2'b10
    } state_t;

    state_t state;
    state_t state_next;

    logic vggo_q;
    logic halt_q;
    logic halt_rise;

    ////////////////////
    // edge detect
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            vggo_q      <= 1'b0;
            halt_q      <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            vggo_q      <= vggo;
            halt_q      <= halt;
            // one pulse per rising vggo, a held level starts nothing more
            frame_start <= vggo && !vggo_q;
        end
    end

    assign halt_rise = halt && !halt_q;

    ////////////////////
    // handover sequencer
    ////////////////////

    // each step holds until its condition shows up
    always_comb begin
        state_next = state;
        case (state)
            idle:        if (halt_rise) state_next = halted;
            halted:      if (lrq_empty) state_next = queue_empty;
            queue_empty: if (line_done) state_next = idle;
            default:     state_next = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // swap lands on the same edge that sees line_done
    assign read_swap = (state == queue_empty) && line_done;

    a_swap_order : assert property (
        @(posedge clk) disable iff (rst)
        read_swap |-> (state == queue_empty) ##1 (state == idle)
    ) else $error("swap_sync: read_swap outside queue_empty");

endmodule

`default_nettype wire

//--- logic/fb_top.sv
`timescale 1ns/10ps
`default_nettype none

module fb_top #(
    parameter int H_PIXELS = fb_pkg::H_PIXELS,
    parameter int V_PIXELS = fb_pkg::V_PIXELS,
    parameter int RED_ROWS = fb_pkg::RED_ROWS
) (
    input wire                    clk,
    input wire                    rst,

    // writer
    input wire fb_pkg::fb_addr_t  w_addr,
    input wire                    en_w,
    input wire fb_pkg::pixel_t    color_in,

    // scan-out
    input wire fb_pkg::row_t      row,
    input wire fb_pkg::col_t      col,
    input wire                    en_r,

    // swap control
    input wire                    vggo,
    input wire                    halt,
    input wire                    lrq_empty,
    input wire                    line_done,

    output fb_pkg::pixel_t        red_out,
    output fb_pkg::pixel_t        green_out,
    output fb_pkg::pixel_t        blue_out
);

    logic frame_start;
    logic read_swap;

    fb_bank_if bank_a ();
    fb_bank_if bank_b ();

    ////////////////////
    // handover
    ////////////////////

    swap_sync u_swap_sync (
        .clk         (clk),
        .rst         (rst),
        .vggo        (vggo),
        .halt        (halt),
        .lrq_empty   (lrq_empty),
        .line_done   (line_done),
        .frame_start (frame_start),
        .read_swap   (read_swap)
    );

    ////////////////////
    // controller and banks
    ////////////////////

    fb_controller #(
        .H_PIXELS (H_PIXELS),
        .V_PIXELS (V_PIXELS),
        .RED_ROWS (RED_ROWS)
    ) u_controller (
        .clk         (clk),
        .rst         (rst),
        .frame_start (frame_start),
        .read_swap   (read_swap),
        .w_addr      (w_addr),
        .en_w        (en_w),
        .color_in    (color_in),
        .row         (row),
        .col         (col),
        .en_r        (en_r),
        .bank_a      (bank_a.ctrl),
        .bank_b      (bank_b.ctrl),
        .red_out     (red_out),
        .green_out   (green_out),
        .blue_out    (blue_out)
    );

    fb_bank u_bank_a (
        .clk  (clk),
        .bank (bank_a.mem)
    );

    fb_bank u_bank_b (
        .clk  (clk),
        .bank (bank_b.mem)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

// free running testbench clock
module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- testbench/fb_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fb_tb;

    localparam int H = 16;
    localparam int V = 12;
    localparam int RED = 3;
    localparam int WORDS = H * V;
    // 20 clear periods plus a margin in ns
    localparam int WATCHDOG_NS = (20 * WORDS + 500) * 100;

    logic             clk;
    logic             rst;
    fb_pkg::fb_addr_t w_addr;
    logic             en_w;
    fb_pkg::pixel_t   color_in;
    fb_pkg::row_t     row;
    fb_pkg::col_t     col;
    logic             en_r;
    logic             vggo;
    logic             halt;
    logic             lrq_empty;
    logic             line_done;
    fb_pkg::pixel_t   red_out;
    fb_pkg::pixel_t   green_out;
    fb_pkg::pixel_t   blue_out;

    // expected contents of bank A (0) and bank B (1)
    fb_pkg::pixel_t   frame [2][WORDS];
    logic [31:0]      lfsr;
    int               errors;

    tb_clock #(.PERIOD_NS(100)) u_clock (.clk(clk));

    fb_top #(
        .H_PIXELS (H),
        .V_PIXELS (V),
        .RED_ROWS (RED)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .w_addr    (w_addr),
        .en_w      (en_w),
        .color_in  (color_in),
        .row       (row),
        .col       (col),
        .en_r      (en_r),
        .vggo      (vggo),
        .halt      (halt),
        .lrq_empty (lrq_empty),
        .line_done (line_done),
        .red_out   (red_out),
        .green_out (green_out),
        .blue_out  (blue_out)
    );

    ////////////////////
    // checks
    ////////////////////

    task automatic abort_run(input string why);
        errors++;
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_pixel(input string name, input fb_pkg::pixel_t got,
                               input fb_pkg::pixel_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_zero_blue(input fb_pkg::pixel_t got);
        check_pixel("blue_out", got, '0);
    endtask

    // rows up to RED land on red and the rest on green
    task automatic check_read(input int r, input fb_pkg::pixel_t exp);
        if (r <= RED) begin
            check_pixel("red_out", red_out, exp);
            check_pixel("green_out", green_out, '0);
        end else begin
            check_pixel("red_out", red_out, '0);
            check_pixel("green_out", green_out, exp);
        end
        check_zero_blue(blue_out);
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // taps 32 22 2 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_color(output fb_pkg::pixel_t c);
        for (int i = 0; i < $bits(fb_pkg::pixel_t); i++) begin
            lfsr = lfsr_next(lfsr);
            c = {c[2:0], lfsr[0]};
        end
    endtask

    // all drive tasks start and end on a falling edge
    task automatic write_pixel(input int addr, input fb_pkg::pixel_t c);
        w_addr = fb_pkg::fb_addr_t'(addr);
        color_in = c;
        en_w = 1'b1;
        @(negedge clk);
        en_w = 1'b0;
    endtask

    task automatic write_frame(input int bank);
        fb_pkg::pixel_t c;
        for (int a = 0; a < WORDS; a++) begin
            random_color(c);
            frame[bank][a] = c;
            write_pixel(a, c);
        end
    endtask

    // one read in flight with its result checked on the next falling edge
    task automatic read_frame(input int bank);
        for (int a = 0; a <= WORDS; a++) begin
            if (a > 0) begin
                check_read((a - 1) / H, frame[bank][a - 1]);
            end
            en_r = (a < WORDS);
            row = fb_pkg::row_t'(a / H);
            col = fb_pkg::col_t'(a % H);
            @(negedge clk);
        end
    endtask

    task automatic start_frame(input logic keep_high);
        vggo = 1'b1;
        @(negedge clk);
        vggo = keep_high;
        // role changes one edge after frame_start
        @(negedge clk);
        @(negedge clk);
    endtask

    task automatic handover();
        halt = 1'b1;
        @(negedge clk);
        halt = 1'b0;
        lrq_empty = 1'b1;
        @(negedge clk);
        lrq_empty = 1'b0;
        line_done = 1'b1;
        @(negedge clk);
        line_done = 1'b0;
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_basic_swap();
        start_frame(1'b0);
        write_frame(1);
        handover();
        read_frame(1);
    endtask

    task automatic test_banding();
        int rows [4];
        rows = '{0, RED, RED + 1, V - 1};
        foreach (rows[i]) begin
            row = fb_pkg::row_t'(rows[i]);
            col = fb_pkg::col_t'(5);
            en_r = 1'b1;
            @(negedge clk);
            en_r = 1'b0;
            check_read(rows[i], frame[1][rows[i] * H + 5]);
            @(negedge clk);
            // no read so the output blanks
            check_read(rows[i], '0);
        end
    endtask

    task automatic test_clear();
        fb_pkg::pixel_t c;
        repeat (WORDS) @(negedge clk);
        for (int a = 0; a < WORDS; a++) begin
            frame[0][a] = '0;
        end
        start_frame(1'b0);
        for (int i = 0; i < 6; i++) begin
            random_color(c);
            frame[0][i * 37] = c;
            write_pixel(i * 37, c);
        end
        handover();
        read_frame(0);
    endtask

    task automatic test_stray_writes();
        for (int i = 0; i < 6; i++) begin
            write_pixel(i * 37 + 1, ~frame[0][i * 37 + 1]);
        end
        read_frame(0);
    endtask

    task automatic test_handover_order();
        start_frame(1'b1);
        write_frame(1);
        // line_done alone
        line_done = 1'b1;
        @(negedge clk);
        line_done = 1'b0;
        read_frame(0);
        // halt and line_done with the queue not empty
        halt = 1'b1;
        @(negedge clk);
        halt = 1'b0;
        line_done = 1'b1;
        @(negedge clk);
        line_done = 1'b0;
        read_frame(0);
        // finish the waiting sequence
        lrq_empty = 1'b1;
        @(negedge clk);
        lrq_empty = 1'b0;
        line_done = 1'b1;
        @(negedge clk);
        line_done = 1'b0;
        read_frame(1);
        // vggo still high so no new frame and no swap
        handover();
        read_frame(1);
        vggo = 1'b0;
        @(negedge clk);
        start_frame(1'b0);
        write_frame(0);
        handover();
        read_frame(0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        errors = 0;
        lfsr = 32'h92ea_177f;
        rst = 1'b1;
        w_addr = '0;
        en_w = 1'b0;
        color_in = '0;
        row = '0;
        col = '0;
        en_r = 1'b0;
        vggo = 1'b0;
        halt = 1'b0;
        lrq_empty = 1'b0;
        line_done = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        test_basic_swap();
        test_banding();
        test_clear();
        test_stray_writes();
        test_handover_order();
        if (errors == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "errors were counted");
        end
    end

endmodule

`default_nettype wire

//--- fb_top.f
common/fb_pkg.sv
common/fb_bank_if.sv
frame_buffer/fb_bank.sv
frame_buffer/fb_controller.sv
logic/swap_sync.sv
logic/fb_top.sv
testbench/tb_clock.sv
testbench/fb_tb.sv
